// ==== design/link_pkg.sv ====
package link_pkg;

  localparam int WORD_W     = 32;                   // Data word width.
  localparam int BIT_CYCLES = 4;                    // Clocks per serial bit.
  localparam int FIFO_DEPTH = 16;                   // Words per FIFO.
  localparam int COUNT_W    = 5;                    // Holds 0 to FIFO_DEPTH.
  localparam int PTR_W      = $clog2(FIFO_DEPTH);   // FIFO pointer width.
  localparam int RST_HOLD   = 32;                   // Extra reset cycles.
  localparam int HOLD_W     = $clog2(RST_HOLD + 1); // Stretch counter width.
  localparam int FRAME_BITS = WORD_W + 2;           // Start, data, stop.
  localparam int TIMER_W    = $clog2(BIT_CYCLES);   // Bit-time counter width.
  localparam int BITCNT_W   = $clog2(FRAME_BITS);   // Bit index width.
  localparam int LEN_W      = 16;                   // Payload length field.

  typedef enum logic {
    DATA    = 1'b0,
    CONTROL = 1'b1
  } link_kind_t;

  typedef struct packed {
    link_kind_t       kind;  // Bit 31.
    logic [14:0]      rsvd;
    logic [LEN_W-1:0] len;   // Payload words after the header.
  } link_data_hdr_t;

  typedef struct packed {
    link_kind_t  kind;       // Bit 31.
    logic [6:0]  opcode;
    logic [23:0] arg;
  } link_ctrl_hdr_t;

  // Same header word, two decodes.
  typedef union packed {
    link_data_hdr_t data;
    link_ctrl_hdr_t ctrl;
  } link_header_t;

endpackage

// ==== design/apb_regs_pkg.sv ====
package apb_regs_pkg;

  localparam int ADDR_W = 8;  // APB address width.

  localparam logic [ADDR_W-1:0] REG_TXDATA  = 8'h00;  // Write pushes TX FIFO.
  localparam logic [ADDR_W-1:0] REG_RXDATA  = 8'h04;  // Read pops RX FIFO.
  localparam logic [ADDR_W-1:0] REG_CMD     = 8'h08;  // Write sends a header.
  localparam logic [ADDR_W-1:0] REG_STATUS  = 8'h0C;  // Read-only flags.
  localparam logic [ADDR_W-1:0] REG_CTRL_RX = 8'h10;  // Last control word.
  localparam logic [ADDR_W-1:0] REG_ERR_CLR = 8'h14;  // Write clears errors.

  localparam int ST_BUSY         = 0;  // Transmitter running.
  localparam int ST_IRQ          = 1;  // Control word pending.
  localparam int ST_ERR_REJECT   = 2;  // Command refused.
  localparam int ST_ERR_OVERFLOW = 3;  // Word lost on a full FIFO.
  localparam int ST_RXCOUNT      = 8;  // LSB of receive count field.

endpackage

// ==== design/reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch import link_pkg::*; (
  input  logic CPU_CLK,
  input  logic RST,
  output logic link_rst
);

  logic [HOLD_W-1:0] cnt;  // Cycles since RST went high.

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      cnt      <= '0;
      link_rst <= 1'b0;  // Adapter held in reset.
    end else if (!link_rst) begin
      cnt      <= cnt + 1'b1;
      link_rst <= (cnt == HOLD_W'(RST_HOLD - 1));  // Release after RST_HOLD.
    end
  end

endmodule

// ==== design/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo import link_pkg::*; (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               push,
  input  logic [WORD_W-1:0]  wdata,
  input  logic               pop,
  output logic [WORD_W-1:0]  rdata,
  output logic [COUNT_W-1:0] count,
  output logic               full,
  output logic               empty
);

  logic [WORD_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;  // Next free slot.
  logic [PTR_W-1:0]  rd_ptr;  // Head entry.
  logic              do_push;
  logic              do_pop;

  assign full    = (count == COUNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;   // Push on full is ignored.
  assign do_pop  = pop && !empty;   // Pop on empty is ignored.
  assign rdata   = mem[rd_ptr];     // Fall-through head.

  // Depth is a power of two, so the pointers wrap on their own.
  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + COUNT_W'(do_push) - COUNT_W'(do_pop);  // Net change.
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

endmodule

// ==== design/link_tx.sv ====
`timescale 1ns/1ps

module link_tx import link_pkg::*; (
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              tx_start,
  input  link_header_t      tx_header,
  output logic              tx_busy,
  output logic              fifo_pop,
  input  logic [WORD_W-1:0] fifo_rdata,
  output logic              serial_tx
);

  logic [FRAME_BITS-1:0] frame;       // Stop, data, start; LSB goes out first.
  logic [TIMER_W-1:0]    timer;       // Cycle within the bit.
  logic [BITCNT_W-1:0]   bit_cnt;     // Bit within the word.
  logic [LEN_W-1:0]      words_left;  // Payload words still to send.
  logic                  bit_end;
  logic                  word_end;

  assign bit_end   = tx_busy && (timer == TIMER_W'(BIT_CYCLES - 1));
  assign word_end  = bit_end && (bit_cnt == BITCNT_W'(FRAME_BITS - 1));
  assign fifo_pop  = word_end && (words_left != '0);  // Next word joins back to back.
  assign serial_tx = tx_busy ? frame[0] : 1'b1;       // Idle line is high.

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      tx_busy    <= 1'b0;
      timer      <= '0;
      bit_cnt    <= '0;
      words_left <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy    <= 1'b1;
        timer      <= '0;
        bit_cnt    <= '0;
        // Only a data header carries payload.
        words_left <= (tx_header.data.kind == DATA) ? tx_header.data.len : '0;
      end
    end else begin
      timer <= bit_end ? '0 : timer + 1'b1;
      if (word_end) begin
        bit_cnt <= '0;
        if (fifo_pop)
          words_left <= words_left - 1'b1;
        else
          tx_busy <= 1'b0;  // Last stop bit done.
      end else if (bit_end) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (tx_start && !tx_busy)
      frame <= {1'b1, tx_header, 1'b0};   // Header word.
    else if (fifo_pop)
      frame <= {1'b1, fifo_rdata, 1'b0};  // Payload word.
    else if (bit_end)
      frame <= frame >> 1;
  end

endmodule

// ==== design/link_rx.sv ====
`timescale 1ns/1ps

module link_rx import link_pkg::*; (
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              serial_rx,
  output logic              fifo_push,
  output logic [WORD_W-1:0] fifo_wdata,
  input  logic              fifo_full,
  output logic              ctrl_valid,
  output logic [WORD_W-1:0] ctrl_word,
  output logic              rx_drop
);

  logic                active;      // Inside a word.
  logic                rx_prev;     // Line one cycle ago.
  logic [TIMER_W-1:0]  timer;       // Cycle within the bit.
  logic [BITCNT_W-1:0] bit_cnt;     // Bit within the word.
  logic [LEN_W-1:0]    words_left;  // Payload words still expected.
  link_header_t        rx_word;     // Shift register, LSB first.
  logic                mid;
  logic                last_bit;
  logic                word_ok;
  logic                payload;

  assign mid        = active && (timer == TIMER_W'(BIT_CYCLES / 2));
  assign last_bit   = (bit_cnt == BITCNT_W'(FRAME_BITS - 1));
  assign word_ok    = mid && last_bit && serial_rx;  // Good stop bit.
  assign payload    = (words_left != '0);
  assign fifo_push  = word_ok && payload && !fifo_full;
  assign rx_drop    = word_ok && payload && fifo_full;
  assign ctrl_valid = word_ok && !payload && (rx_word.ctrl.kind == CONTROL);
  assign fifo_wdata = rx_word;
  assign ctrl_word  = rx_word;

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      active     <= 1'b0;
      rx_prev    <= 1'b1;
      timer      <= '0;
      bit_cnt    <= '0;
      words_left <= '0;
    end else begin
      rx_prev <= serial_rx;
      if (!active) begin
        if (rx_prev && !serial_rx) begin  // Falling start edge.
          active  <= 1'b1;
          timer   <= TIMER_W'(1);         // Edge cycle was position 0.
          bit_cnt <= '0;
        end
      end else begin
        timer <= (timer == TIMER_W'(BIT_CYCLES - 1)) ? '0 : timer + 1'b1;
        if (timer == TIMER_W'(BIT_CYCLES - 1))
          bit_cnt <= bit_cnt + 1'b1;
        if (mid && (bit_cnt == '0) && serial_rx)
          active <= 1'b0;  // Glitch, not a start bit.
        if (mid && last_bit) begin
          active <= 1'b0;  // Rearm for the next start edge.
          if (word_ok && payload)
            words_left <= words_left - 1'b1;
          else if (word_ok && (rx_word.data.kind == DATA))
            words_left <= rx_word.data.len;  // Header opens a payload.
        end
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (mid && (bit_cnt != '0) && !last_bit)
      rx_word <= {serial_rx, rx_word[WORD_W-1:1]};  // Data bits only.
  end

endmodule

// ==== design/link_ctrl.sv ====
`timescale 1ns/1ps

module link_ctrl import link_pkg::*, apb_regs_pkg::*; (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [ADDR_W-1:0]  paddr,
  input  logic [WORD_W-1:0]  pwdata,
  output logic [WORD_W-1:0]  prdata,
  output logic               pslverr,
  output logic               tx_push,
  output logic [WORD_W-1:0]  tx_wdata,
  input  logic [COUNT_W-1:0] tx_count,
  input  logic               tx_full,
  output logic               tx_start,
  output link_header_t       tx_header,
  input  logic               tx_busy,
  output logic               rx_pop,
  input  logic [WORD_W-1:0]  rx_rdata,
  input  logic [COUNT_W-1:0] rx_count,
  input  logic               rx_empty,
  input  logic               ctrl_valid,
  input  logic [WORD_W-1:0]  ctrl_word,
  input  logic               rx_drop,
  output logic               irq
);

  logic              access;        // APB access cycle.
  logic              reject;        // CMD not allowed now.
  logic              tx_ovf;
  logic              cmd_rej;
  logic              ctrl_rd;
  logic              err_clr;
  logic              err_reject;
  logic              err_overflow;
  logic [WORD_W-1:0] ctrl_reg;      // Last control header seen.
  logic [WORD_W-1:0] status;
  link_header_t      cmd_hdr;

  assign access    = psel && penable;
  assign cmd_hdr   = pwdata;
  assign tx_header = cmd_hdr;
  assign tx_wdata  = pwdata;
  // Busy, or the payload is not all queued yet.
  assign reject    = tx_busy ||
                     ((cmd_hdr.data.kind == DATA) && (cmd_hdr.data.len > LEN_W'(tx_count)));

  always_comb begin
    status                        = '0;
    status[ST_BUSY]               = tx_busy;
    status[ST_IRQ]                = irq;
    status[ST_ERR_REJECT]         = err_reject;
    status[ST_ERR_OVERFLOW]       = err_overflow;
    status[ST_RXCOUNT +: COUNT_W] = rx_count;
  end

  always_comb begin
    prdata   = '0;
    pslverr  = 1'b0;
    tx_push  = 1'b0;
    tx_ovf   = 1'b0;
    tx_start = 1'b0;
    cmd_rej  = 1'b0;
    rx_pop   = 1'b0;
    ctrl_rd  = 1'b0;
    err_clr  = 1'b0;
    if (access) begin
      case (paddr)
        REG_TXDATA: begin
          pslverr = !pwrite;           // Write-only.
          tx_push = pwrite && !tx_full;
          tx_ovf  = pwrite && tx_full;
        end
        REG_RXDATA: begin
          pslverr = pwrite;            // Read-only.
          rx_pop  = !pwrite && !rx_empty;
          prdata  = (pwrite || rx_empty) ? '0 : rx_rdata;  // Empty reads 0.
        end
        REG_CMD: begin
          pslverr  = !pwrite;
          tx_start = pwrite && !reject;
          cmd_rej  = pwrite && reject;
        end
        REG_STATUS: begin
          pslverr = pwrite;
          prdata  = pwrite ? '0 : status;
        end
        REG_CTRL_RX: begin
          pslverr = pwrite;
          ctrl_rd = !pwrite;           // Read acknowledges the interrupt.
          prdata  = pwrite ? '0 : ctrl_reg;
        end
        REG_ERR_CLR: begin
          pslverr = !pwrite;
          err_clr = pwrite;
        end
        default: pslverr = 1'b1;       // Unmapped.
      endcase
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      irq          <= 1'b0;
      err_reject   <= 1'b0;
      err_overflow <= 1'b0;
      ctrl_reg     <= '0;
    end else begin
      if (ctrl_valid)
        irq <= 1'b1;  // New word wins over a clearing read.
      else if (ctrl_rd)
        irq <= 1'b0;
      if (ctrl_valid)
        ctrl_reg <= ctrl_word;
      if (cmd_rej)
        err_reject <= 1'b1;
      else if (err_clr)
        err_reject <= 1'b0;
      if (tx_ovf || rx_drop)
        err_overflow <= 1'b1;  // Either FIFO lost a word.
      else if (err_clr)
        err_overflow <= 1'b0;
    end
  end

endmodule

// ==== design/link_chip.sv ====
`timescale 1ns/1ps

module link_chip import link_pkg::*, apb_regs_pkg::*; (
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [WORD_W-1:0] pwdata,
  output logic [WORD_W-1:0] prdata,
  output logic              pslverr,
  output logic              irq,
  output logic              serial_tx,
  input  logic              serial_rx
);

  logic               link_rst;    // Stretched adapter reset.
  logic               tx_push;
  logic [WORD_W-1:0]  tx_wdata;
  logic               tx_pop;
  logic [WORD_W-1:0]  tx_rdata;
  logic [COUNT_W-1:0] tx_count;
  logic               tx_full;
  logic               tx_start;
  link_header_t       tx_header;
  logic               tx_busy;
  logic               rx_push;
  logic [WORD_W-1:0]  rx_wdata;
  logic               rx_pop;
  logic [WORD_W-1:0]  rx_rdata;
  logic [COUNT_W-1:0] rx_count;
  logic               rx_full;
  logic               rx_empty;
  logic               ctrl_valid;
  logic [WORD_W-1:0]  ctrl_word;
  logic               rx_drop;

  reset_stretch u_reset_stretch (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .link_rst (link_rst)
  );

  link_ctrl u_link_ctrl (
    .CPU_CLK    (CPU_CLK),
    .RST        (link_rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .tx_push    (tx_push),
    .tx_wdata   (tx_wdata),
    .tx_count   (tx_count),
    .tx_full    (tx_full),
    .tx_start   (tx_start),
    .tx_header  (tx_header),
    .tx_busy    (tx_busy),
    .rx_pop     (rx_pop),
    .rx_rdata   (rx_rdata),
    .rx_count   (rx_count),
    .rx_empty   (rx_empty),
    .ctrl_valid (ctrl_valid),
    .ctrl_word  (ctrl_word),
    .rx_drop    (rx_drop),
    .irq        (irq)
  );

  // Transmit queue; link_ctrl checks the CMD length against its count.
  word_fifo u_tx_fifo (
    .CPU_CLK (CPU_CLK),
    .RST     (link_rst),
    .push    (tx_push),
    .wdata   (tx_wdata),
    .pop     (tx_pop),
    .rdata   (tx_rdata),
    .count   (tx_count),
    .full    (tx_full),
    .empty   ()
  );

  link_tx u_link_tx (
    .CPU_CLK    (CPU_CLK),
    .RST        (link_rst),
    .tx_start   (tx_start),
    .tx_header  (tx_header),
    .tx_busy    (tx_busy),
    .fifo_pop   (tx_pop),
    .fifo_rdata (tx_rdata),
    .serial_tx  (serial_tx)
  );

  link_rx u_link_rx (
    .CPU_CLK    (CPU_CLK),
    .RST        (link_rst),
    .serial_rx  (serial_rx),
    .fifo_push  (rx_push),
    .fifo_wdata (rx_wdata),
    .fifo_full  (rx_full),
    .ctrl_valid (ctrl_valid),
    .ctrl_word  (ctrl_word),
    .rx_drop    (rx_drop)
  );

  word_fifo u_rx_fifo (
    .CPU_CLK (CPU_CLK),
    .RST     (link_rst),
    .push    (rx_push),
    .wdata   (rx_wdata),
    .pop     (rx_pop),
    .rdata   (rx_rdata),
    .count   (rx_count),
    .full    (rx_full),
    .empty   (rx_empty)
  );

endmodule

// ==== verif/link_chip_properties.sv ====
`timescale 1ns/1ps

module link_chip_properties (
  input logic CPU_CLK,
  input logic link_rst,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic tx_push,
  input logic tx_start,
  input logic rx_pop,
  input logic tx_busy,
  input logic serial_tx
);

  // Zero wait states, so an access cycle lasts one clock.
  a_setup_first: assert property (@(posedge CPU_CLK) disable iff (!link_rst)
    penable |-> psel && $past(psel) && !$past(penable))
    else $error("penable high without a preceding setup cycle");

  // Idle line is high, and so was the stop bit before it.
  a_idle_high: assert property (@(posedge CPU_CLK) disable iff (!link_rst)
    !tx_busy |-> serial_tx && $past(serial_tx))
    else $error("serial_tx low while idle or at the last stop bit");

  // A refused access pushes, pops and launches nothing.
  a_err_in_access: assert property (@(posedge CPU_CLK) disable iff (!link_rst)
    pslverr |-> psel && penable && !tx_push && !tx_start && !rx_pop)
    else $error("pslverr high outside an access cycle or with a side effect");

endmodule

bind link_chip link_chip_properties u_link_chip_properties (
  .CPU_CLK   (CPU_CLK),
  .link_rst  (link_rst),
  .psel      (psel),
  .penable   (penable),
  .pslverr   (pslverr),
  .tx_push   (tx_push),
  .tx_start  (tx_start),
  .rx_pop    (rx_pop),
  .tx_busy   (tx_busy),
  .serial_tx (serial_tx)
);

// ==== verif/link_chip_tb.sv ====
`timescale 1ns/1ps

module link_chip_tb import link_pkg::*, apb_regs_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 60000;  // Frames plus polling, with margin.
  localparam int SEED           = 16;

  logic              CPU_CLK;
  logic              RST;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [WORD_W-1:0] pwdata;
  logic [WORD_W-1:0] prdata;
  logic              pslverr;
  logic              irq;
  logic              serial_tx;
  logic              serial_rx;

  logic [WORD_W-1:0] tx_model [$];   // Words queued in the TX FIFO.
  logic [WORD_W-1:0] rx_expect [$];  // Words due out of RXDATA.
  logic [WORD_W-1:0] rx_seen [$];    // RXDATA reads not yet compared.
  logic [WORD_W-1:0] exp_ctrl;
  bit                exp_irq;
  bit                exp_reject;
  bit                exp_overflow;
  bit                busy_model;     // A frame is on the line.
  int unsigned       cycles;
  event              read_done;

  assign serial_rx = serial_tx;  // Loopback.

  link_chip u_link_chip (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .irq       (irq),
    .serial_tx (serial_tx),
    .serial_rx (serial_rx)
  );

  initial begin
    CPU_CLK = 1'b0;
    forever #5 CPU_CLK = ~CPU_CLK;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure("value check failed");
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    forever begin
      @(posedge CPU_CLK);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
        stop_with_failure("timeout: the run did not finish within the cycle limit");
    end
  end

  // Expected receive queue and control word for one issued command.
  function automatic bit model_cmd(input logic [WORD_W-1:0] hdr, input bit busy);
    int unsigned len;
    if (busy) begin
      exp_reject = 1'b1;  // Refused while a frame is running.
      return 1'b0;
    end
    if (hdr[31] == 1'b0) begin  // Data header.
      len = int'(hdr[LEN_W-1:0]);
      if (len > tx_model.size()) begin
        exp_reject = 1'b1;  // Payload not all queued.
        return 1'b0;
      end
      repeat (len) begin
        if (rx_expect.size() < FIFO_DEPTH)
          rx_expect.push_back(tx_model.pop_front());
        else begin
          void'(tx_model.pop_front());
          exp_overflow = 1'b1;  // RX FIFO full, word lost.
        end
      end
    end else begin
      exp_ctrl = hdr;  // Control header lands in CTRL_RX.
      exp_irq  = 1'b1;
    end
    return 1'b1;
  endfunction

  function automatic logic [WORD_W-1:0] data_header(input int unsigned len);
    return {1'b0, 15'd0, LEN_W'(len)};
  endfunction

  function automatic logic [WORD_W-1:0] ctrl_header(input logic [6:0] op,
                                                     input logic [23:0] arg);
    return {1'b1, op, arg};
  endfunction

  task automatic apb_transfer(input bit write, input logic [ADDR_W-1:0] addr,
                              input logic [WORD_W-1:0] wdata,
                              output logic [WORD_W-1:0] rdata, output bit err);
    @(posedge CPU_CLK);
    psel    <= 1'b1;  // Setup cycle.
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge CPU_CLK);
    penable <= 1'b1;  // Access cycle.
    @(negedge CPU_CLK);
    rdata = prdata;   // Stable mid-cycle.
    err   = pslverr;
    @(posedge CPU_CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                           output bit err);
    logic [WORD_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
                          output bit err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic push_tx_word(input logic [WORD_W-1:0] data);
    bit err;
    apb_write(REG_TXDATA, data, err);
    check_equal("pslverr", 32'(err), 32'd0);
    if (tx_model.size() < FIFO_DEPTH)
      tx_model.push_back(data);
    else
      exp_overflow = 1'b1;  // TX FIFO full, write dropped.
  endtask

  task automatic send_cmd(input logic [WORD_W-1:0] hdr);
    bit err;
    apb_write(REG_CMD, hdr, err);
    check_equal("pslverr", 32'(err), 32'd0);
    busy_model = busy_model | model_cmd(hdr, busy_model);
  endtask

  task automatic wait_idle();
    logic [WORD_W-1:0] st;
    bit                err;
    st = '1;
    while (st[ST_BUSY])
      apb_read(REG_STATUS, st, err);  // Poll BUSY.
    busy_model = 1'b0;
  endtask

  task automatic check_status();
    logic [WORD_W-1:0] got;
    logic [WORD_W-1:0] exp;
    bit                err;
    apb_read(REG_STATUS, got, err);
    exp                        = '0;  // Built after the read, queues settled.
    exp[ST_IRQ]                = exp_irq;
    exp[ST_ERR_REJECT]         = exp_reject;
    exp[ST_ERR_OVERFLOW]       = exp_overflow;
    exp[ST_RXCOUNT +: COUNT_W] = COUNT_W'(rx_expect.size());
    check_equal("pslverr", 32'(err), 32'd0);
    check_equal("prdata (STATUS)", got, exp);
  endtask

  task automatic read_rx_word();
    logic [WORD_W-1:0] data;
    bit                err;
    apb_read(REG_RXDATA, data, err);
    check_equal("pslverr", 32'(err), 32'd0);
    rx_seen.push_back(data);
    -> read_done;
  endtask

  task automatic read_ctrl();
    logic [WORD_W-1:0] data;
    bit                err;
    apb_read(REG_CTRL_RX, data, err);
    check_equal("pslverr", 32'(err), 32'd0);
    check_equal("prdata (CTRL_RX)", data, exp_ctrl);
    exp_irq = 1'b0;  // Read acknowledges.
  endtask

  task automatic clear_errors();
    bit err;
    apb_write(REG_ERR_CLR, '0, err);
    check_equal("pslverr", 32'(err), 32'd0);
    exp_reject   = 1'b0;
    exp_overflow = 1'b0;
  endtask

  initial begin : compare_rx
    logic [WORD_W-1:0] got;
    forever begin
      @(read_done);
      while (rx_seen.size() > 0) begin
        got = rx_seen.pop_front();
        if (rx_expect.size() == 0)
          stop_with_failure("RXDATA returned a word that no frame carried");
        else
          check_equal("prdata (RXDATA)", got, rx_expect.pop_front());
      end
    end
  end

  initial begin : tests
    logic [WORD_W-1:0] data;
    bit                err;
    int unsigned       len;
    void'($urandom(SEED));
    RST     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    exp_ctrl = '0;
    repeat (4) @(posedge CPU_CLK);
    RST <= 1'b1;
    repeat (RST_HOLD + 2) @(posedge CPU_CLK);  // Wait out the stretch.

    @(negedge CPU_CLK);
    check_equal("serial_tx", 32'(serial_tx), 32'd1);
    check_status();
    apb_read(REG_RXDATA, data, err);
    check_equal("pslverr", 32'(err), 32'd0);
    check_equal("prdata (RXDATA empty)", data, '0);

    len = $urandom_range(1, 8);  // Random data frame.
    repeat (len) push_tx_word($urandom);
    send_cmd(data_header(len));
    wait_idle();
    check_status();
    repeat (len) read_rx_word();

    send_cmd(ctrl_header(7'($urandom), 24'($urandom)));  // Control frame.
    wait_idle();
    @(negedge CPU_CLK);
    check_equal("irq", 32'(irq), 32'd1);
    check_status();
    read_ctrl();
    @(negedge CPU_CLK);
    check_equal("irq", 32'(irq), 32'd0);

    repeat (2) push_tx_word($urandom);  // Length beyond the queue.
    send_cmd(data_header(3));
    check_status();
    clear_errors();
    send_cmd(data_header(2));
    send_cmd(ctrl_header(7'h11, 24'h00abcd));  // Lands while busy.
    wait_idle();
    check_status();
    repeat (2) read_rx_word();
    clear_errors();
    check_status();

    push_tx_word($urandom);  // Bad accesses must not touch it.
    send_cmd(data_header(2));  // Refused, leaves ERR_REJECT set.
    apb_write(8'h18, $urandom, err);
    check_equal("pslverr (unmapped write)", 32'(err), 32'd1);
    apb_read(8'h18, data, err);
    check_equal("pslverr (unmapped read)", 32'(err), 32'd1);
    apb_write(REG_STATUS, '1, err);
    check_equal("pslverr (STATUS write)", 32'(err), 32'd1);
    apb_read(REG_TXDATA, data, err);
    check_equal("pslverr (TXDATA read)", 32'(err), 32'd1);
    check_status();
    read_ctrl();

    repeat (4) push_tx_word($urandom);  // Mixed frames in a row.
    send_cmd(data_header(2));
    wait_idle();
    send_cmd(ctrl_header(7'($urandom), 24'($urandom)));
    wait_idle();
    send_cmd(data_header(3));
    wait_idle();
    check_status();
    read_ctrl();
    repeat (5) read_rx_word();

    repeat (FIFO_DEPTH + 1) push_tx_word($urandom);  // One too many.
    check_status();
    send_cmd(data_header(FIFO_DEPTH));
    wait_idle();
    check_status();
    repeat (FIFO_DEPTH) read_rx_word();
    clear_errors();
    check_status();

    @(posedge CPU_CLK);
    check_equal("expected words left", 32'(rx_expect.size()), 32'd0);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== link_chip.f ====
design/link_pkg.sv
design/apb_regs_pkg.sv
design/reset_stretch.sv
design/word_fifo.sv
design/link_tx.sv
design/link_rx.sv
design/link_ctrl.sv
design/link_chip.sv
verif/link_chip_properties.sv
verif/link_chip_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the link_chip testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    -f link_chip.f --top-module link_chip_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vlink_chip_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1
